//--- filelist.f
+incdir+rtl
rtl/execPkg.sv
rtl/aluCore.sv
rtl/executeStage.sv
rtl/execCreditCtl.sv
rtl/execConfig.sv
rtl/execUnitTop.sv
tb/execUnitTb.sv

//--- rtl/aluCore.sv
// combinational alu of the execute stage: add/sub with overflow, xor, and-not, rotates and shifts
`timescale 1ns/1ps

module aluCore (
   input  execPkg::wordT  inA,
   input  execPkg::wordT  inB,
   input  execPkg::aluOpT op,
   output execPkg::wordT  out,
   output logic           zero,
   output logic           ofl
);
   import execPkg::*;

   localparam int WordW = $bits(wordT);

   wordT         sum;
   wordT         diff;
   logic [3:0]   shAmt;
   logic [4:0]   backAmt;
   logic         addOfl;
   logic         subOfl;

   // rotate and shift distance from the low bits only
   assign shAmt   = inB[3:0];
   // bits that wrap around on a rotate
   assign backAmt = 5'(WordW) - {1'b0, shAmt};

   assign sum  = inA + inB;
   assign diff = inA - inB;

   // same-sign inputs giving an opposite-sign sum
   assign addOfl = (inA[WordW-1] == inB[WordW-1]) && (sum[WordW-1] != inA[WordW-1]);
   // differing signs and result sign flipped from inA
   assign subOfl = (inA[WordW-1] != inB[WordW-1]) && (diff[WordW-1] != inA[WordW-1]);

   always_comb begin
      out = sum;
      ofl = 1'b0;
      case (op)
         aluAdd: begin
            out = sum;
            ofl = addOfl;
         end
         aluSub: begin
            out = diff;
            ofl = subOfl;
         end
         aluXor:  out = inA ^ inB;
         aluAndn: out = inA & ~inB;
         // a shift by 0 leaves inA, the wrap term shifts out entirely
         aluRol:  out = (inA << shAmt) | (inA >> backAmt);
         aluSll:  out = inA << shAmt;
         aluRor:  out = (inA >> shAmt) | (inA << backAmt);
         aluSrl:  out = inA >> shAmt;
         default: begin
            out = sum;
            ofl = 1'b0;
         end
      endcase
   end

   // zero flag on the final word, branches rely on it
   assign zero = (out == '0);

endmodule

//--- rtl/execConfig.sv
// host-visible control and status registers for credit limit, overflow trap and credit error
`timescale 1ns/1ps
`include "exec_consts.svh"

module execConfig (
   input  logic            clk,
   input  logic            reset,
   input  logic            cfgWrite,
   input  logic            cfgAddr,
   input  execPkg::wordT   cfgWdata,
   input  logic            creditError,
   output execPkg::wordT   cfgRdata,
   output execPkg::creditT creditLimit,
   output logic            oflTrapEn,
   output logic            creditRestart
);
   import execPkg::*;

   logic ctrlWrite;

   assign ctrlWrite = cfgWrite && (cfgAddr == `CFG_ADDR_CTRL);

   // limit in bits 2:0, trap enable in bit 8
   always_ff @(posedge clk) begin
      if (reset) begin
         creditLimit   <= creditT'(`EXEC_CREDITS_DEFAULT);
         oflTrapEn     <= 1'b0;
         creditRestart <= 1'b0;
      end else begin
         creditRestart <= ctrlWrite;
         if (ctrlWrite) begin
            creditLimit <= cfgWdata[`EXEC_CRED_W-1:0];
            oflTrapEn   <= cfgWdata[8];
         end
      end
   end

   always_comb begin
      cfgRdata = '0;
      if (cfgAddr == `CFG_ADDR_STAT) begin
         cfgRdata[0] = creditError;
      end else begin
         cfgRdata[`EXEC_CRED_W-1:0] = creditLimit;
         cfgRdata[8]                = oflTrapEn;
      end
   end

   // a zero limit would lock the issuer out for good
   limitNonZero: assert property (@(posedge clk) disable iff (reset)
      ctrlWrite |=> creditLimit != '0);

endmodule

//--- rtl/execCreditCtl.sv
// stage B: registers stage A results and tracks outstanding results against the credit limit
`timescale 1ns/1ps

module execCreditCtl (
   input  logic            clk,
   input  logic            reset,
   input  logic            stageValid,
   input  execPkg::wordT   result,
   input  execPkg::wordT   newPc,
   input  logic            ofl,
   input  logic            trap,
   input  logic            creditReturn,
   input  execPkg::creditT creditLimit,
   input  logic            creditRestart,
   output logic            resultValid,
   output execPkg::wordT   resultOut,
   output execPkg::wordT   newPcOut,
   output logic            oflOut,
   output logic            trapOut,
   output logic            issueCredit,
   output logic            creditError
);
   import execPkg::*;

   creditT    outCount;
   creditT    nextCount;
   credStateT credState;
   credStateT nextState;
   logic      violate;

   // each drained result goes straight back to the issuer
   assign issueCredit = creditReturn;

   // return with nothing outstanding, or one more result than the consumer holds
   assign violate = (creditReturn && outCount == '0) ||
                    (stageValid && !creditReturn && outCount >= creditLimit);

   always_comb begin
      nextCount = outCount + creditT'(stageValid) - creditT'(creditReturn);
      if (creditRestart) begin
         nextCount = '0;
      end
      if (violate || credState == credViolated) begin
         nextState = credViolated;
      end else if (nextCount != '0) begin
         nextState = credActive;
      end else begin
         nextState = credIdle;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         outCount    <= '0;
         credState   <= credIdle;
         resultValid <= 1'b0;
         oflOut      <= 1'b0;
         trapOut     <= 1'b0;
      end else begin
         outCount    <= nextCount;
         credState   <= nextState;
         resultValid <= stageValid;
         // flags only show alongside a valid result
         oflOut      <= stageValid & ofl;
         trapOut     <= stageValid & trap;
      end
   end

   always_ff @(posedge clk) begin
      if (stageValid) begin
         resultOut <= result;
         newPcOut  <= newPc;
      end
   end

   assign creditError = (credState == credViolated);

   // consumer never returns more credits than results it got
   noUnderflow: assert property (@(posedge clk) disable iff (reset)
      creditReturn |-> outCount != '0);
   // issuer never issues past the limit
   noOverflow: assert property (@(posedge clk) disable iff (reset)
      (stageValid && !creditReturn) |-> outCount < creditLimit);

endmodule

//--- rtl/execPkg.sv
// types shared by the execute unit; modules import it inside their body
`include "exec_consts.svh"

package execPkg;

   // one data word, also used for the pc
   typedef logic [`EXEC_WORD_W-1:0] wordT;

   // major opcode field
   typedef logic [`EXEC_OPC_W-1:0] opcodeT;

   // low function field of R-forms
   typedef logic [1:0] funcT;

   // outstanding result count
   typedef logic [`EXEC_CRED_W-1:0] creditT;

   // operation class the alu performs
   typedef enum logic [2:0] {
      aluAdd, aluSub, aluXor, aluAndn,
      aluRol, aluSll, aluRor, aluSrl
   } aluOpT;

   // credit controller state, violated is sticky
   typedef enum logic [1:0] {
      credIdle, credActive, credViolated
   } credStateT;

endpackage

//--- rtl/execUnitTop.sv
// execute unit top: config block beside a two-stage execute pipeline with credit flow control
`timescale 1ns/1ps

module execUnitTop (
   input  logic          clk,
   input  logic          reset,
   input  logic          issueValid,
   input  execPkg::wordT instr,
   input  execPkg::wordT regData1,
   input  execPkg::wordT regData2,
   input  execPkg::wordT immVal,
   input  execPkg::wordT incPc,
   output logic          issueCredit,
   output logic          resultValid,
   output execPkg::wordT result,
   output execPkg::wordT newPc,
   output logic          ofl,
   output logic          trap,
   input  logic          creditReturn,
   input  logic          cfgWrite,
   input  logic          cfgAddr,
   input  execPkg::wordT cfgWdata,
   output execPkg::wordT cfgRdata
);
   import execPkg::*;

   // stage A to stage B
   logic   stageValid;
   wordT   stageResult;
   wordT   stagePc;
   logic   stageOfl;
   logic   stageTrap;
   // config to pipeline
   creditT creditLimit;
   logic   oflTrapEn;
   logic   creditRestart;
   logic   creditError;

   execConfig execConfig_inst (
      .clk (clk), .reset (reset),
      .cfgWrite (cfgWrite), .cfgAddr (cfgAddr), .cfgWdata (cfgWdata),
      .creditError (creditError), .cfgRdata (cfgRdata),
      .creditLimit (creditLimit), .oflTrapEn (oflTrapEn), .creditRestart (creditRestart)
   );

   executeStage executeStage_inst (
      .clk (clk), .reset (reset), .issueValid (issueValid), .instr (instr),
      .regData1 (regData1), .regData2 (regData2), .immVal (immVal), .incPc (incPc),
      .oflTrapEn (oflTrapEn), .stageValid (stageValid), .result (stageResult),
      .newPc (stagePc), .ofl (stageOfl), .trap (stageTrap)
   );

   execCreditCtl execCreditCtl_inst (
      .clk (clk), .reset (reset), .stageValid (stageValid),
      .result (stageResult), .newPc (stagePc), .ofl (stageOfl), .trap (stageTrap),
      .creditReturn (creditReturn), .creditLimit (creditLimit), .creditRestart (creditRestart),
      .resultValid (resultValid), .resultOut (result), .newPcOut (newPc),
      .oflOut (ofl), .trapOut (trap), .issueCredit (issueCredit), .creditError (creditError)
   );

endmodule

//--- rtl/exec_consts.svh
// shared widths, opcode and function encodings, config addresses; include wherever a value is needed
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// datapath widths
`define EXEC_WORD_W 16
`define EXEC_OPC_W 5
`define EXEC_CRED_W 3
// results the consumer can buffer after reset
`define EXEC_CREDITS_DEFAULT 4

// major opcodes, instr[15:11]
`define OPC_J     5'b00100
`define OPC_JR    5'b00101
`define OPC_ADDI  5'b01000
`define OPC_SUBI  5'b01001
`define OPC_XORI  5'b01010
`define OPC_ANDNI 5'b01011
`define OPC_BEQZ  5'b01100
`define OPC_BNEZ  5'b01101
`define OPC_BLTZ  5'b01110
`define OPC_BGEZ  5'b01111
`define OPC_ST    5'b10000
`define OPC_LD    5'b10001
`define OPC_SLBI  5'b10010
`define OPC_ROLI  5'b10100
`define OPC_SLLI  5'b10101
`define OPC_RORI  5'b10110
`define OPC_SRLI  5'b10111
`define OPC_BTR   5'b11001
`define OPC_SHFR  5'b11010
`define OPC_ALUR  5'b11011
`define OPC_SEQ   5'b11100
`define OPC_SLT   5'b11101
`define OPC_SLE   5'b11110
`define OPC_SCO   5'b11111

// function field instr[1:0] for ALUR
`define FN_ADD  2'b00
`define FN_SUB  2'b01
`define FN_XOR  2'b10
`define FN_ANDN 2'b11
// function field instr[1:0] for SHFR
`define FN_ROL 2'b00
`define FN_SLL 2'b01
`define FN_ROR 2'b10
`define FN_SRL 2'b11

// config register map
`define CFG_ADDR_CTRL 1'b0
`define CFG_ADDR_STAT 1'b1

`endif

//--- rtl/executeStage.sv
// execute stage A: decodes and registers an issued instruction, then resolves result and next pc
`timescale 1ns/1ps
`include "exec_consts.svh"

module executeStage (
   input  logic          clk,
   input  logic          reset,
   input  logic          issueValid,
   input  execPkg::wordT instr,
   input  execPkg::wordT regData1,
   input  execPkg::wordT regData2,
   input  execPkg::wordT immVal,
   input  execPkg::wordT incPc,
   input  logic          oflTrapEn,
   output logic          stageValid,
   output execPkg::wordT result,
   output execPkg::wordT newPc,
   output logic          ofl,
   output logic          trap
);
   import execPkg::*;

   // decode of the incoming instruction
   opcodeT decOpc;
   funcT   decFn;
   aluOpT  decOp;
   wordT   decOpB;
   logic   decArith;
   logic   decLegal;
   // stage A registers
   opcodeT opcA;
   aluOpT  aluOpA;
   wordT   rd1A;
   wordT   rd2A;
   wordT   immA;
   wordT   incPcA;
   wordT   opBA;
   logic   arithA;
   logic   legalA;
   // resolution
   wordT   aluOut;
   logic   aluZero;
   logic   aluOfl;
   logic [`EXEC_WORD_W:0] carrySum;
   logic   setBit;
   logic   taken;
   wordT   jumpPc;
   wordT   revBits;

   assign decOpc = instr[15:11];
   assign decFn  = instr[1:0];

   // pick alu op and second operand, I-forms take the immediate
   always_comb begin
      decOp    = aluAdd;
      decOpB   = immVal;
      decArith = 1'b0;
      decLegal = 1'b1;
      case (decOpc)
         `OPC_ADDI: decArith = 1'b1;
         `OPC_SUBI: begin
            decOp    = aluSub;
            decArith = 1'b1;
         end
         `OPC_XORI:  decOp = aluXor;
         `OPC_ANDNI: decOp = aluAndn;
         `OPC_ROLI:  decOp = aluRol;
         `OPC_SLLI:  decOp = aluSll;
         `OPC_RORI:  decOp = aluRor;
         `OPC_SRLI:  decOp = aluSrl;
         `OPC_ALUR: begin
            decOpB   = regData2;
            decOp    = aluOpT'({1'b0, decFn});
            decArith = (decFn == `FN_ADD) || (decFn == `FN_SUB);
         end
         `OPC_SHFR: begin
            decOpB = regData2;
            decOp  = aluOpT'({1'b1, decFn});
         end
         // branches pass regData1 through the adder for the zero and sign test
         `OPC_BEQZ, `OPC_BNEZ, `OPC_BLTZ, `OPC_BGEZ: decOpB = '0;
         // base plus immediate, jr target the same way
         `OPC_ST, `OPC_LD, `OPC_JR: decOp = aluAdd;
         `OPC_SLBI, `OPC_BTR, `OPC_SEQ, `OPC_SLT, `OPC_SLE, `OPC_SCO, `OPC_J: decOp = aluAdd;
         default: decLegal = 1'b0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         stageValid <= 1'b0;
      end else begin
         stageValid <= issueValid;
      end
   end

   // payload loads only on an issue
   always_ff @(posedge clk) begin
      if (issueValid) begin
         opcA   <= decOpc;
         aluOpA <= decOp;
         rd1A   <= regData1;
         rd2A   <= regData2;
         immA   <= immVal;
         incPcA <= incPc;
         opBA   <= decOpB;
         arithA <= decArith;
         legalA <= decLegal;
      end
   end

   aluCore aluCore_inst (
      .inA  (rd1A),
      .inB  (opBA),
      .op   (aluOpA),
      .out  (aluOut),
      .zero (aluZero),
      .ofl  (aluOfl)
   );

   // carry out of the unsigned register sum for sco
   assign carrySum = {1'b0, rd1A} + {1'b0, rd2A};
   assign jumpPc   = incPcA + immA;

   always_comb begin
      for (int i = 0; i < `EXEC_WORD_W; i++) begin
         revBits[i] = rd1A[`EXEC_WORD_W-1-i];
      end
   end

   always_comb begin
      case (opcA)
         `OPC_SEQ: setBit = (rd1A == rd2A);
         `OPC_SLT: setBit = ($signed(rd1A) < $signed(rd2A));
         `OPC_SLE: setBit = ($signed(rd1A) <= $signed(rd2A));
         default:  setBit = carrySum[`EXEC_WORD_W];
      endcase
      // aluOut equals regData1 on a branch
      case (opcA)
         `OPC_BEQZ: taken = aluZero;
         `OPC_BNEZ: taken = !aluZero;
         `OPC_BLTZ: taken = aluOut[`EXEC_WORD_W-1];
         default:   taken = !aluOut[`EXEC_WORD_W-1];
      endcase
   end

   always_comb begin
      result = aluOut;
      newPc  = incPcA;
      case (opcA)
         `OPC_SLBI: result = (rd1A << 8) | immA;
         `OPC_BTR:  result = revBits;
         `OPC_SEQ, `OPC_SLT, `OPC_SLE, `OPC_SCO: result = wordT'(setBit);
         `OPC_BEQZ, `OPC_BNEZ, `OPC_BLTZ, `OPC_BGEZ: begin
            result = '0;
            newPc  = taken ? jumpPc : incPcA;
         end
         `OPC_J: begin
            result = '0;
            newPc  = jumpPc;
         end
         `OPC_JR: newPc = aluOut;
         default: newPc = incPcA;
      endcase
   end

   // overflow only counts for the add and sub classes
   assign ofl  = arithA & aluOfl;
   assign trap = ofl & oflTrapEn;

   // the issuer only sends defined opcodes
   legalOpcode: assert property (@(posedge clk) disable iff (reset) stageValid |-> legalA);

endmodule

//--- tb/execUnitTb.sv
// testbench for the execute unit: table-driven issue with a credit-aware issuer and a consumer model
`timescale 1ns/1ps
`include "exec_consts.svh"

module execUnitTb;
   import execPkg::*;

   // one stimulus row with the values the unit should return
   typedef struct packed {
      wordT instr;
      wordT rd1;
      wordT rd2;
      wordT imm;
      wordT pc;
      wordT expResult;
      wordT expPc;
      logic expOfl;
      logic expTrap;
   } rowT;

   logic   clk;
   logic   reset;
   logic   issueValid;
   wordT   instr;
   wordT   regData1;
   wordT   regData2;
   wordT   immVal;
   wordT   incPc;
   logic   issueCredit;
   logic   resultValid;
   wordT   result;
   wordT   newPc;
   logic   ofl;
   logic   trap;
   logic   creditReturn;
   logic   cfgWrite;
   logic   cfgAddr;
   wordT   cfgWdata;
   wordT   cfgRdata;

   rowT    stim[$];
   // issued rows waiting for their result, in issue order
   rowT    expQ[$];
   // per drained result, cycles until its credit goes back
   int     delays[$];
   integer seed;
   int     credits;
   int     outstanding;
   int     limitModel;
   logic   trapEnModel;
   logic   paused;
   logic   returnNext;
   int     resultsSeen;
   int     errCount;
   int     otherFails;
   int     checkCount;
   int     cycleCount;
   int     cycleLimit;
   logic   tableBuilt;
   int     pauseStart;
   int     cfgStart;

   execUnitTop execUnitTop_inst (
      .clk (clk), .reset (reset), .issueValid (issueValid), .instr (instr),
      .regData1 (regData1), .regData2 (regData2), .immVal (immVal), .incPc (incPc),
      .issueCredit (issueCredit), .resultValid (resultValid), .result (result),
      .newPc (newPc), .ofl (ofl), .trap (trap), .creditReturn (creditReturn),
      .cfgWrite (cfgWrite), .cfgAddr (cfgAddr), .cfgWdata (cfgWdata), .cfgRdata (cfgRdata)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #20 clk = ~clk;
      end
   end

   task automatic checkWord(input wordT got, input wordT exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkFlag(input logic got, input logic exp, input string what);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // signed add or subtract, overflow when the true sum leaves the 16-bit range
   task automatic addRef(input wordT a, input wordT b, input logic subtract,
                         output wordT res, output logic ov);
      int s;
      if (subtract)
         s = $signed(a) - $signed(b);
      else
         s = $signed(a) + $signed(b);
      res = s[15:0];
      ov  = (s > 32767) || (s < -32768);
   endtask

   // rotates through a doubled word, shifts fill with zeros
   function automatic wordT shiftRef(input wordT a, input funcT kind, input logic [3:0] n);
      logic [31:0] dbl;
      dbl = {a, a};
      case (kind)
         `FN_ROL: begin
            dbl = dbl << n;
            return dbl[31:16];
         end
         `FN_SLL: return a << n;
         `FN_ROR: begin
            dbl = dbl >> n;
            return dbl[15:0];
         end
         default: return a >> n;
      endcase
   endfunction

   // expected result, next pc and overflow of one instruction
   task automatic refExec(input wordT ins, input wordT a, input wordT b, input wordT imm,
                          input wordT pc, output wordT res, output wordT npc, output logic ov);
      opcodeT opc;
      funcT   fn;
      int     u;
      int     i;
      opc = ins[15:11];
      fn  = ins[1:0];
      res = '0;
      npc = pc;
      ov  = 1'b0;
      case (opc)
         `OPC_ADDI:  addRef(a, imm, 1'b0, res, ov);
         `OPC_SUBI:  addRef(a, imm, 1'b1, res, ov);
         `OPC_XORI:  res = a ^ imm;
         `OPC_ANDNI: res = a & ~imm;
         `OPC_ROLI:  res = shiftRef(a, `FN_ROL, imm[3:0]);
         `OPC_SLLI:  res = shiftRef(a, `FN_SLL, imm[3:0]);
         `OPC_RORI:  res = shiftRef(a, `FN_ROR, imm[3:0]);
         `OPC_SRLI:  res = shiftRef(a, `FN_SRL, imm[3:0]);
         `OPC_ALUR: begin
            case (fn)
               `FN_ADD: addRef(a, b, 1'b0, res, ov);
               `FN_SUB: addRef(a, b, 1'b1, res, ov);
               `FN_XOR: res = a ^ b;
               default: res = a & ~b;
            endcase
         end
         `OPC_SHFR:         res = shiftRef(a, fn, b[3:0]);
         `OPC_ST, `OPC_LD:  res = a + imm;
         `OPC_SLBI:         res = {a[7:0], 8'h00} | imm;
         `OPC_BTR: begin
            for (i = 0; i < 16; i++) begin
               res[i] = a[15-i];
            end
         end
         `OPC_SEQ: res = {15'b0, a == b};
         `OPC_SLT: res = {15'b0, $signed(a) < $signed(b)};
         `OPC_SLE: res = {15'b0, $signed(a) <= $signed(b)};
         `OPC_SCO: begin
            // unsigned sum past 16 bits means carry out
            u   = a + b;
            res = {15'b0, u > 65535};
         end
         `OPC_BEQZ: if (a == 16'h0000) npc = pc + imm;
         `OPC_BNEZ: if (a != 16'h0000) npc = pc + imm;
         `OPC_BLTZ: if (a[15]) npc = pc + imm;
         `OPC_BGEZ: if (!a[15]) npc = pc + imm;
         `OPC_J:    npc = pc + imm;
         `OPC_JR: begin
            res = a + imm;
            npc = a + imm;
         end
         default: res = '0;
      endcase
   endtask

   task automatic addRow(input opcodeT opc, input funcT fn, input wordT a, input wordT b,
                         input wordT imm, input wordT pc);
      rowT r;
      // middle bits are register fields, the unit ignores them
      r.instr   = {opc, 9'h0a5, fn};
      r.rd1     = a;
      r.rd2     = b;
      r.imm     = imm;
      r.pc      = pc;
      r.expTrap = 1'b0;
      refExec(r.instr, a, b, imm, pc, r.expResult, r.expPc, r.expOfl);
      stim.push_back(r);
   endtask

   // random add, sub, xor, and-not rows in I and R forms
   task automatic addRandomRows(input int n);
      int   k;
      wordT a;
      wordT b;
      wordT imm;
      repeat (n) begin
         k   = {$random(seed)} % 8;
         a   = wordT'($random(seed));
         b   = wordT'($random(seed));
         imm = wordT'($random(seed));
         case (k)
            0:       addRow(`OPC_ADDI, 2'b00, a, b, imm, 16'h0200);
            1:       addRow(`OPC_SUBI, 2'b00, a, b, imm, 16'h0200);
            2:       addRow(`OPC_XORI, 2'b00, a, b, imm, 16'h0200);
            3:       addRow(`OPC_ANDNI, 2'b00, a, b, imm, 16'h0200);
            default: addRow(`OPC_ALUR, funcT'(k - 4), a, b, imm, 16'h0200);
         endcase
      end
   endtask

   task automatic buildStimulus();
      // arithmetic and logic, overflow corners first
      addRow(`OPC_ADDI, 2'b00, 16'h7fff, 16'h0000, 16'h0001, 16'h0100);
      addRow(`OPC_ADDI, 2'b00, 16'h1234, 16'h0000, 16'h0010, 16'h0100);
      addRow(`OPC_SUBI, 2'b00, 16'h8000, 16'h0000, 16'h0001, 16'h0100);
      addRow(`OPC_SUBI, 2'b00, 16'h0005, 16'h0000, 16'h0007, 16'h0100);
      addRow(`OPC_XORI, 2'b00, 16'ha5a5, 16'h0000, 16'h0ff0, 16'h0100);
      addRow(`OPC_ANDNI, 2'b00, 16'hf0f0, 16'h0000, 16'h3c3c, 16'h0100);
      addRow(`OPC_ALUR, `FN_ADD, 16'h4000, 16'h4000, 16'h0000, 16'h0100);
      addRow(`OPC_ALUR, `FN_SUB, 16'h7fff, 16'hffff, 16'h0000, 16'h0100);
      addRow(`OPC_ALUR, `FN_XOR, 16'h1357, 16'h2468, 16'h0000, 16'h0100);
      addRow(`OPC_ALUR, `FN_ANDN, 16'hffff, 16'h00ff, 16'h0000, 16'h0100);
      addRandomRows(12);
      // rotates, shifts, byte insert, bit reverse, addresses
      addRow(`OPC_ROLI, 2'b00, 16'h8001, 16'h0000, 16'h0001, 16'h0104);
      addRow(`OPC_SLLI, 2'b00, 16'h00ff, 16'h0000, 16'h0004, 16'h0104);
      addRow(`OPC_RORI, 2'b00, 16'h0003, 16'h0000, 16'h0001, 16'h0104);
      addRow(`OPC_SRLI, 2'b00, 16'h8000, 16'h0000, 16'h000f, 16'h0104);
      addRow(`OPC_SHFR, `FN_ROL, 16'h1234, 16'h0104, 16'h0000, 16'h0104);
      addRow(`OPC_SHFR, `FN_SLL, 16'h1234, 16'h0000, 16'h0000, 16'h0104);
      addRow(`OPC_SHFR, `FN_ROR, 16'h1234, 16'h0008, 16'h0000, 16'h0104);
      addRow(`OPC_SHFR, `FN_SRL, 16'hf00f, 16'h0003, 16'h0000, 16'h0104);
      addRow(`OPC_SLBI, 2'b00, 16'h00ab, 16'h0000, 16'h00cd, 16'h0104);
      addRow(`OPC_BTR, 2'b00, 16'h0001, 16'h0000, 16'h0000, 16'h0104);
      addRow(`OPC_LD, 2'b00, 16'h1000, 16'h0000, 16'hfffe, 16'h0104);
      addRow(`OPC_ST, 2'b00, 16'h2000, 16'h0000, 16'h0004, 16'h0104);
      // set-condition, mixed signs included
      addRow(`OPC_SEQ, 2'b00, 16'h1234, 16'h1234, 16'h0000, 16'h0108);
      addRow(`OPC_SEQ, 2'b00, 16'h1234, 16'h1235, 16'h0000, 16'h0108);
      addRow(`OPC_SLT, 2'b00, 16'h8000, 16'h0001, 16'h0000, 16'h0108);
      addRow(`OPC_SLT, 2'b00, 16'h0001, 16'h8000, 16'h0000, 16'h0108);
      addRow(`OPC_SLE, 2'b00, 16'h0005, 16'h0005, 16'h0000, 16'h0108);
      addRow(`OPC_SLE, 2'b00, 16'h0006, 16'hfffb, 16'h0000, 16'h0108);
      addRow(`OPC_SCO, 2'b00, 16'hffff, 16'h0001, 16'h0000, 16'h0108);
      addRow(`OPC_SCO, 2'b00, 16'h0001, 16'h0001, 16'h0000, 16'h0108);
      // branches taken and not taken, then jumps
      addRow(`OPC_BEQZ, 2'b00, 16'h0000, 16'h0000, 16'h0010, 16'h0100);
      addRow(`OPC_BEQZ, 2'b00, 16'h0005, 16'h0000, 16'h0010, 16'h0100);
      addRow(`OPC_BNEZ, 2'b00, 16'h0005, 16'h0000, 16'hfff0, 16'h0100);
      addRow(`OPC_BNEZ, 2'b00, 16'h0000, 16'h0000, 16'hfff0, 16'h0100);
      addRow(`OPC_BLTZ, 2'b00, 16'h8000, 16'h0000, 16'h0020, 16'h0100);
      addRow(`OPC_BLTZ, 2'b00, 16'h0001, 16'h0000, 16'h0020, 16'h0100);
      addRow(`OPC_BGEZ, 2'b00, 16'h0001, 16'h0000, 16'h0030, 16'h0100);
      addRow(`OPC_BGEZ, 2'b00, 16'hffff, 16'h0000, 16'h0030, 16'h0100);
      addRow(`OPC_J, 2'b00, 16'h0000, 16'h0000, 16'h0020, 16'h0100);
      addRow(`OPC_JR, 2'b00, 16'h0400, 16'h0000, 16'h0008, 16'h0100);
      pauseStart = stim.size();
      addRandomRows(6);
      cfgStart = stim.size();
      // trap rows run after the control write
      addRow(`OPC_ADDI, 2'b00, 16'h7fff, 16'h0000, 16'h0001, 16'h0300);
      addRow(`OPC_ADDI, 2'b00, 16'h0001, 16'h0000, 16'h0002, 16'h0300);
      addRow(`OPC_ALUR, `FN_SUB, 16'h8000, 16'h0001, 16'h0000, 16'h0300);
      addRow(`OPC_XORI, 2'b00, 16'h7fff, 16'h0000, 16'h8000, 16'h0300);
      addRow(`OPC_LD, 2'b00, 16'h7fff, 16'h0000, 16'h0001, 16'h0300);
   endtask

   // issue rows first..last-1, one per cycle while a credit is held
   task automatic issueRows(input int first, input int last);
      int  i;
      rowT e;
      i = first;
      while (i < last) begin
         @(posedge clk);
         if (credits > 0) begin
            issueValid <= 1'b1;
            instr      <= stim[i].instr;
            regData1   <= stim[i].rd1;
            regData2   <= stim[i].rd2;
            immVal     <= stim[i].imm;
            incPc      <= stim[i].pc;
            e          = stim[i];
            e.expTrap  = e.expOfl & trapEnModel;
            expQ.push_back(e);
            credits--;
            outstanding++;
            i++;
         end else begin
            issueValid <= 1'b0;
         end
      end
      @(posedge clk);
      issueValid <= 1'b0;
   endtask

   task automatic waitDrained();
      while (outstanding != 0 || expQ.size() != 0) begin
         @(posedge clk);
      end
   endtask

   // new limit and trap enable, issuer restarts with the full new limit
   task automatic writeControl(input wordT value);
      @(posedge clk);
      cfgWrite <= 1'b1;
      cfgAddr  <= `CFG_ADDR_CTRL;
      cfgWdata <= value;
      @(posedge clk);
      cfgWrite <= 1'b0;
      @(negedge clk);
      checkWord(cfgRdata, value, "control register readback");
      @(posedge clk);
      cfgAddr     <= `CFG_ADDR_STAT;
      credits     = int'(value[2:0]);
      limitModel  = int'(value[2:0]);
      trapEnModel = value[8];
   endtask

   // consumer model, sampled mid-cycle where outputs are settled
   always @(negedge clk) begin : consumerModel
      rowT e;
      int  dropped;
      if (!reset) begin
         if (issueCredit !== creditReturn) begin
            otherFails++;
            $display("issueCredit did not follow creditReturn at time %0t", $time);
         end
         if (issueCredit === 1'b1) begin
            credits++;
         end
         // a result leaves the consumer buffer only when its credit goes back
         if (creditReturn === 1'b1) begin
            outstanding--;
         end
         if (outstanding > limitModel) begin
            otherFails++;
            $display("more results outstanding than the credit limit at time %0t", $time);
         end
         if (resultValid === 1'b1) begin
            if (expQ.size() == 0) begin
               otherFails++;
               $display("a result arrived with no instruction in flight at time %0t", $time);
            end else begin
               e = expQ.pop_front();
               checkWord(result, e.expResult, $sformatf("result of instr %h", e.instr));
               checkWord(newPc, e.expPc, $sformatf("newPc of instr %h", e.instr));
               checkFlag(ofl, e.expOfl, $sformatf("ofl of instr %h", e.instr));
               checkFlag(trap, e.expTrap, $sformatf("trap of instr %h", e.instr));
               delays.push_back({$random(seed)} % 4);
               resultsSeen++;
            end
         end
         // head of the drain queue counts down, one return per cycle
         returnNext = 1'b0;
         if (!paused && delays.size() > 0) begin
            if (delays[0] == 0) begin
               returnNext = 1'b1;
               dropped    = delays.pop_front();
            end else begin
               delays[0] = delays[0] - 1;
            end
         end
         if (cfgAddr == `CFG_ADDR_STAT && !cfgWrite) begin
            checkFlag(cfgRdata[0], 1'b0, "creditError status");
         end
      end
   end

   always @(posedge clk) begin
      creditReturn <= returnNext;
   end

   // run limit grows with the table
   initial begin
      cycleCount = 0;
      wait (tableBuilt === 1'b1);
      while (cycleCount < cycleLimit) begin
         @(posedge clk);
         cycleCount++;
      end
      $display("timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Something failed");
      $finish;
   end

   initial begin
      reset        = 1'b1;
      issueValid   = 1'b0;
      instr        = '0;
      regData1     = '0;
      regData2     = '0;
      immVal       = '0;
      incPc        = '0;
      creditReturn = 1'b0;
      cfgWrite     = 1'b0;
      cfgAddr      = `CFG_ADDR_STAT;
      cfgWdata     = '0;
      returnNext   = 1'b0;
      paused       = 1'b0;
      credits      = `EXEC_CREDITS_DEFAULT;
      limitModel   = `EXEC_CREDITS_DEFAULT;
      trapEnModel  = 1'b0;
      outstanding  = 0;
      resultsSeen  = 0;
      errCount     = 0;
      otherFails   = 0;
      checkCount   = 0;
      tableBuilt   = 1'b0;
      seed         = 91742;
      buildStimulus();
      cycleLimit = stim.size() * 8 + 200;
      tableBuilt = 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      issueRows(0, pauseStart);

      // consumer holds its credits, issuer must run dry at the limit
      waitDrained();
      paused      = 1'b1;
      resultsSeen = 0;
      issueRows(pauseStart, pauseStart + limitModel);
      repeat (8) @(posedge clk);
      if (credits != 0 || resultsSeen != limitModel) begin
         otherFails++;
         $display("with the consumer paused %0d results came and %0d credits were left",
                  resultsSeen, credits);
      end
      paused = 1'b0;
      issueRows(pauseStart + limitModel, cfgStart);

      // limit 2 and overflow trap on
      waitDrained();
      writeControl(16'h0102);
      issueRows(cfgStart, stim.size());

      waitDrained();
      repeat (4) @(posedge clk);
      if (credits != limitModel) begin
         otherFails++;
         $display("the issuer ended with %0d credits instead of %0d", credits, limitModel);
      end
      $display("checks %0d, value errors %0d, other failures %0d",
               checkCount, errCount, otherFails);
      if (errCount == 0 && otherFails == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule
